// ==== common/ex_pipe_pkg.sv ====
package ex_pipe_pkg;

    localparam int UOP_QUEUE_DEPTH = 4;
    localparam int CREDIT_W        = 3; // Holds 0 up to the full depth

    typedef enum logic [4:0] {
        ALU_X,
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        MUL,
        MULH,
        MULHSU,
        MULHU,
        DIV,
        DIVU,
        REM,
        REMU,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } exe_fun_e;

    typedef struct packed {
        logic [31:0]           pc;
        rv_isa_pkg::rv_instr_u word;
        logic [31:0]           rs1_val;
        logic [31:0]           rs2_val;
    } fetch_pkt_t;

    typedef struct packed {
        logic [31:0] pc;
        exe_fun_e    exe_fun;
        logic [31:0] op1;
        logic [31:0] op2;   // rs2 value or sign-extended I immediate
        logic [31:0] imm_b;
        logic [4:0]  rd;
        logic        rf_wen;
    } uop_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        rf_wen;
        logic [31:0] alu_out;
        logic        br_flg;
        logic [31:0] br_target;
    } ex_result_t;

endpackage

// ==== common/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Base integer funct3 values are shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'd0;
    localparam logic [2:0] F3_SLL     = 3'd1;
    localparam logic [2:0] F3_SLT     = 3'd2;
    localparam logic [2:0] F3_SLTU    = 3'd3;
    localparam logic [2:0] F3_XOR     = 3'd4;
    localparam logic [2:0] F3_SRL_SRA = 3'd5;
    localparam logic [2:0] F3_OR      = 3'd6;
    localparam logic [2:0] F3_AND     = 3'd7;

    localparam logic [2:0] F3_MUL     = 3'd0;
    localparam logic [2:0] F3_MULH    = 3'd1;
    localparam logic [2:0] F3_MULHSU  = 3'd2;
    localparam logic [2:0] F3_MULHU   = 3'd3;
    localparam logic [2:0] F3_DIV     = 3'd4;
    localparam logic [2:0] F3_DIVU    = 3'd5;
    localparam logic [2:0] F3_REM     = 3'd6;
    localparam logic [2:0] F3_REMU    = 3'd7;

    localparam logic [2:0] F3_BEQ     = 3'd0;
    localparam logic [2:0] F3_BNE     = 3'd1;
    localparam logic [2:0] F3_BLT     = 3'd4;
    localparam logic [2:0] F3_BGE     = 3'd5;
    localparam logic [2:0] F3_BLTU    = 3'd6;
    localparam logic [2:0] F3_BGEU    = 3'd7;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000; // SUB and SRA/SRAI
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
    } rv_instr_u;

endpackage

// ==== execute/alu_unit.sv ====
`timescale 1ns/1ns

module alu_unit (
    input  ex_pipe_pkg::uop_t uop,
    output logic [31:0]       alu_out,
    output logic              br_flg,
    output logic [31:0]       br_target
);

    logic [31:0] op1;
    logic [31:0] op2;
    logic [63:0] mul_ss;
    logic [63:0] mul_su;
    logic [63:0] mul_uu;
    logic        div_zero;
    logic        div_ovf;
    logic [31:0] divisor;
    logic [31:0] div_s;
    logic [31:0] div_u;
    logic [31:0] rem_s;
    logic [31:0] rem_u;
    logic        lt_s;
    logic        lt_u;

    assign op1 = uop.op1;
    assign op2 = uop.op2;

    // Operands widened to 64 bits so one unsigned product covers every sign mix
    assign mul_ss = {{32{op1[31]}}, op1} * {{32{op2[31]}}, op2};
    assign mul_su = {{32{op1[31]}}, op1} * {32'd0, op2};
    assign mul_uu = {32'd0, op1} * {32'd0, op2};

    assign div_zero = (op2 == 32'd0);
    assign div_ovf  = (op1 == 32'h8000_0000) && (op2 == 32'hffff_ffff);
    assign divisor  = (div_zero || div_ovf) ? 32'd1 : op2; // Corner cases are patched below
    assign div_s    = $signed(op1) / $signed(divisor);
    assign div_u    = op1 / divisor;
    assign rem_s    = $signed(op1) % $signed(divisor);
    assign rem_u    = op1 % divisor;

    assign lt_s = $signed(op1) < $signed(op2);
    assign lt_u = op1 < op2;

    always_comb begin
        case (uop.exe_fun)
            ex_pipe_pkg::ADD:    alu_out = op1 + op2;
            ex_pipe_pkg::SUB:    alu_out = op1 - op2;
            ex_pipe_pkg::AND:    alu_out = op1 & op2;
            ex_pipe_pkg::OR:     alu_out = op1 | op2;
            ex_pipe_pkg::XOR:    alu_out = op1 ^ op2;
            ex_pipe_pkg::SLL:    alu_out = op1 << op2[4:0];
            ex_pipe_pkg::SRL:    alu_out = op1 >> op2[4:0];
            ex_pipe_pkg::SRA:    alu_out = $unsigned($signed(op1) >>> op2[4:0]);
            ex_pipe_pkg::SLT:    alu_out = {31'd0, lt_s};
            ex_pipe_pkg::SLTU:   alu_out = {31'd0, lt_u};
            ex_pipe_pkg::MUL:    alu_out = mul_ss[31:0];
            ex_pipe_pkg::MULH:   alu_out = mul_ss[63:32];
            ex_pipe_pkg::MULHSU: alu_out = mul_su[63:32];
            ex_pipe_pkg::MULHU:  alu_out = mul_uu[63:32];
            ex_pipe_pkg::DIV:    alu_out = div_zero ? 32'hffff_ffff :
                                           div_ovf  ? 32'h8000_0000 : div_s;
            ex_pipe_pkg::DIVU:   alu_out = div_zero ? 32'hffff_ffff : div_u;
            ex_pipe_pkg::REM:    alu_out = div_zero ? op1 : div_ovf ? 32'd0 : rem_s;
            ex_pipe_pkg::REMU:   alu_out = div_zero ? op1 : rem_u;
            default:             alu_out = 32'd0; // Branches and bubbles
        endcase
    end

    always_comb begin
        case (uop.exe_fun)
            ex_pipe_pkg::BEQ:  br_flg = (op1 == op2);
            ex_pipe_pkg::BNE:  br_flg = (op1 != op2);
            ex_pipe_pkg::BLT:  br_flg = lt_s;
            ex_pipe_pkg::BGE:  br_flg = !lt_s;
            ex_pipe_pkg::BLTU: br_flg = lt_u;
            ex_pipe_pkg::BGEU: br_flg = !lt_u;
            default:           br_flg = 1'b0;
        endcase
    end

    assign br_target = uop.pc + uop.imm_b;

endmodule

// ==== execute/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    stall,
    input  ex_pipe_pkg::uop_t       head,
    input  logic                    head_valid,
    output logic                    pop,
    output ex_pipe_pkg::ex_result_t result,
    output logic                    result_valid
);

    logic        can_load;
    logic [31:0] alu_out;
    logic        br_flg;
    logic [31:0] br_target;

    alu_unit alu_i (
        .uop       (head),
        .alu_out   (alu_out),
        .br_flg    (br_flg),
        .br_target (br_target)
    );

    // Register is free when empty or when its result leaves at this edge
    assign can_load = !result_valid || !stall;
    assign pop      = head_valid && can_load;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            result_valid <= 1'b0;
        end else if (can_load) begin
            result_valid <= head_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            result.pc        <= head.pc;
            result.rd        <= head.rd;
            result.rf_wen    <= head.rf_wen;
            result.alu_out   <= alu_out;
            result.br_flg    <= br_flg;
            result.br_target <= br_target;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and decide by the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module ex_subsystem_tb -o ex_subsystem_sim \
    && ./obj_dir/ex_subsystem_sim | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null \
    && echo "run.sh: pass" \
    || { echo "run.sh: fail"; exit 1; }

// ==== sim.f ====
common/rv_isa_pkg.sv
common/ex_pipe_pkg.sv
execute/alu_unit.sv
execute/execute_stage.sv
src/instr_decoder.sv
src/uop_queue.sv
src/ex_subsystem.sv
tests/ex_subsystem_sva.sv
tests/ex_subsystem_tb.sv

// ==== src/ex_subsystem.sv ====
`timescale 1ns/1ns

module ex_subsystem (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    stall,
    input  ex_pipe_pkg::fetch_pkt_t fetch,
    input  logic                    fetch_valid,
    output logic                    fetch_ready,
    output ex_pipe_pkg::ex_result_t result,
    output logic                    result_valid
);

    ex_pipe_pkg::uop_t uop;
    logic              uop_push;
    logic              credit_return;
    ex_pipe_pkg::uop_t head;
    logic              head_valid;
    logic              pop;

    instr_decoder decoder_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .fetch         (fetch),
        .fetch_valid   (fetch_valid),
        .fetch_ready   (fetch_ready),
        .uop           (uop),
        .uop_push      (uop_push),
        .credit_return (credit_return)
    );

    uop_queue queue_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .uop           (uop),
        .uop_push      (uop_push),
        .head          (head),
        .head_valid    (head_valid),
        .pop           (pop),
        .credit_return (credit_return)
    );

    execute_stage execute_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .stall        (stall),
        .head         (head),
        .head_valid   (head_valid),
        .pop          (pop),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// ==== src/instr_decoder.sv ====
`timescale 1ns/1ns

module instr_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  ex_pipe_pkg::fetch_pkt_t fetch,
    input  logic                   fetch_valid,
    output logic                   fetch_ready,
    output ex_pipe_pkg::uop_t      uop,
    output logic                   uop_push,
    input  logic                   credit_return
);

    logic [ex_pipe_pkg::CREDIT_W-1:0] credits;
    logic                             accept;
    rv_isa_pkg::rv_instr_u            word;
    logic [31:0]                      imm_i;
    logic [31:0]                      imm_b;
    ex_pipe_pkg::uop_t                dec;

    assign fetch_ready = (credits != '0) && !flush;
    assign accept      = fetch_valid && fetch_ready;
    assign word        = fetch.word;

    assign imm_i = {{20{word.i_fmt.imm[11]}}, word.i_fmt.imm};
    assign imm_b = {{19{word.b_fmt.imm_12}}, word.b_fmt.imm_12, word.b_fmt.imm_11,
                    word.b_fmt.imm_10_5, word.b_fmt.imm_4_1, 1'b0};

    always_comb begin
        dec         = '0;
        dec.pc      = fetch.pc;
        dec.exe_fun = ex_pipe_pkg::ALU_X;
        dec.op1     = fetch.rs1_val;
        dec.op2     = fetch.rs2_val;
        dec.imm_b   = imm_b;
        case (word.r_fmt.opcode)
            rv_isa_pkg::OPC_OP: begin
                dec.rf_wen = 1'b1;
                if (word.r_fmt.funct7 == rv_isa_pkg::F7_MULDIV) begin
                    // funct3 order matches the enum order from MUL on
                    dec.exe_fun = ex_pipe_pkg::exe_fun_e'(ex_pipe_pkg::MUL + word.r_fmt.funct3);
                end else begin
                    case (word.r_fmt.funct3)
                        rv_isa_pkg::F3_ADD_SUB: dec.exe_fun =
                            (word.r_fmt.funct7 == rv_isa_pkg::F7_ALT) ?
                            ex_pipe_pkg::SUB : ex_pipe_pkg::ADD;
                        rv_isa_pkg::F3_SLL:     dec.exe_fun = ex_pipe_pkg::SLL;
                        rv_isa_pkg::F3_SLT:     dec.exe_fun = ex_pipe_pkg::SLT;
                        rv_isa_pkg::F3_SLTU:    dec.exe_fun = ex_pipe_pkg::SLTU;
                        rv_isa_pkg::F3_XOR:     dec.exe_fun = ex_pipe_pkg::XOR;
                        rv_isa_pkg::F3_SRL_SRA: dec.exe_fun =
                            (word.r_fmt.funct7 == rv_isa_pkg::F7_ALT) ?
                            ex_pipe_pkg::SRA : ex_pipe_pkg::SRL;
                        rv_isa_pkg::F3_OR:      dec.exe_fun = ex_pipe_pkg::OR;
                        default:                dec.exe_fun = ex_pipe_pkg::AND;
                    endcase
                end
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                dec.rf_wen = 1'b1;
                dec.op2    = imm_i; // Shifts use only the low 5 bits
                case (word.i_fmt.funct3)
                    rv_isa_pkg::F3_ADD_SUB: dec.exe_fun = ex_pipe_pkg::ADD;
                    rv_isa_pkg::F3_SLL:     dec.exe_fun = ex_pipe_pkg::SLL;
                    rv_isa_pkg::F3_SLT:     dec.exe_fun = ex_pipe_pkg::SLT;
                    rv_isa_pkg::F3_SLTU:    dec.exe_fun = ex_pipe_pkg::SLTU;
                    rv_isa_pkg::F3_XOR:     dec.exe_fun = ex_pipe_pkg::XOR;
                    rv_isa_pkg::F3_SRL_SRA: dec.exe_fun =
                        (word.r_fmt.funct7 == rv_isa_pkg::F7_ALT) ?
                        ex_pipe_pkg::SRA : ex_pipe_pkg::SRL;
                    rv_isa_pkg::F3_OR:      dec.exe_fun = ex_pipe_pkg::OR;
                    default:                dec.exe_fun = ex_pipe_pkg::AND;
                endcase
            end
            rv_isa_pkg::OPC_BRANCH: begin
                case (word.b_fmt.funct3)
                    rv_isa_pkg::F3_BEQ:  dec.exe_fun = ex_pipe_pkg::BEQ;
                    rv_isa_pkg::F3_BNE:  dec.exe_fun = ex_pipe_pkg::BNE;
                    rv_isa_pkg::F3_BLT:  dec.exe_fun = ex_pipe_pkg::BLT;
                    rv_isa_pkg::F3_BGE:  dec.exe_fun = ex_pipe_pkg::BGE;
                    rv_isa_pkg::F3_BLTU: dec.exe_fun = ex_pipe_pkg::BLTU;
                    rv_isa_pkg::F3_BGEU: dec.exe_fun = ex_pipe_pkg::BGEU;
                    default:             dec.exe_fun = ex_pipe_pkg::ALU_X;
                endcase
            end
            default: dec.exe_fun = ex_pipe_pkg::ALU_X; // Bubble
        endcase
        dec.rd = dec.rf_wen ? word.r_fmt.rd : 5'd0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            credits  <= ex_pipe_pkg::CREDIT_W'(ex_pipe_pkg::UOP_QUEUE_DEPTH);
            uop_push <= 1'b0;
        end else begin
            uop_push <= accept;
            case ({accept, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            uop <= dec;
        end
    end

endmodule

// ==== src/uop_queue.sv ====
`timescale 1ns/1ns

module uop_queue (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  ex_pipe_pkg::uop_t uop,
    input  logic              uop_push,
    output ex_pipe_pkg::uop_t head,
    output logic              head_valid,
    input  logic              pop,
    output logic              credit_return
);

    ex_pipe_pkg::uop_t                                mem [ex_pipe_pkg::UOP_QUEUE_DEPTH];
    logic [$clog2(ex_pipe_pkg::UOP_QUEUE_DEPTH)-1:0] rd_ptr;
    logic [$clog2(ex_pipe_pkg::UOP_QUEUE_DEPTH)-1:0] wr_ptr;
    logic [ex_pipe_pkg::CREDIT_W-1:0]                count;

    function automatic logic [$clog2(ex_pipe_pkg::UOP_QUEUE_DEPTH)-1:0] next_ptr(
        input logic [$clog2(ex_pipe_pkg::UOP_QUEUE_DEPTH)-1:0] ptr
    );
        if (ptr == ex_pipe_pkg::UOP_QUEUE_DEPTH - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            rd_ptr        <= '0;
            wr_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0; // Decoder refills its own credits on flush
        end else begin
            credit_return <= pop;
            if (uop_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({uop_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (uop_push && !flush) begin
            mem[wr_ptr] <= uop;
        end
    end

endmodule

// ==== tests/ex_subsystem_sva.sv ====
`timescale 1ns/1ns

module uop_queue_sva (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             flush,
    input logic                             uop_push,
    input logic                             pop,
    input logic                             credit_return,
    input logic [ex_pipe_pkg::CREDIT_W-1:0] count
);

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(uop_push && count == ex_pipe_pkg::CREDIT_W'(ex_pipe_pkg::UOP_QUEUE_DEPTH)))
        else $error("Push into a full micro-op queue");

    no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(pop && count == '0))
        else $error("Pop from an empty micro-op queue");

    // A flush also drops the micro-op pending in the decoder
    empty_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> count == '0 && !uop_push)
        else $error("Micro-op queue not empty after flush");

    // Nothing is pushed or returned in the first cycle out of reset
    no_credit_after_reset: assert property (@(posedge clk)
        !rst_n |=> !credit_return && !uop_push)
        else $error("Credit returned or micro-op pushed right after reset");

endmodule

bind uop_queue uop_queue_sva queue_sva_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush         (flush),
    .uop_push      (uop_push),
    .pop           (pop),
    .credit_return (credit_return),
    .count         (count)
);

// ==== tests/ex_subsystem_tb.sv ====
`timescale 1ns/1ns

module ex_subsystem_tb;

    localparam int N_BASE    = 60;
    localparam int N_MULDIV  = 40;
    localparam int N_CORNER  = 6;
    localparam int N_BRANCH  = 30;
    localparam int N_STREAM  = 40;
    localparam int N_FULL    = 8;
    localparam int N_FLUSH   = 24;
    localparam int N_BUBBLE  = 6;
    localparam int N_INSTR   = N_BASE + N_MULDIV + N_CORNER + N_BRANCH + N_STREAM +
                               N_FULL + N_FLUSH + N_BUBBLE;
    localparam int CYCLE_LIMIT = 20 * N_INSTR + 200;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    flush;
    logic                    stall;
    ex_pipe_pkg::fetch_pkt_t fetch;
    logic                    fetch_valid;
    logic                    fetch_ready;
    ex_pipe_pkg::ex_result_t result;
    logic                    result_valid;

    ex_pipe_pkg::ex_result_t exp_q[$];
    logic [31:0]             drv_seed   = 32'hcdd2;
    logic [31:0]             stall_seed = 32'hcdd2 ^ 32'h5a5a_0000;
    logic                    stall_rand = 1'b0;
    logic                    stall_hold = 1'b0;
    logic                    use_gaps   = 1'b0;
    int                      accepted   = 0;
    int unsigned             cycles     = 0;

    // Branch operand pairs cover equal, less and greater, then signed and unsigned order disagree
    logic [31:0] br_a [5] = '{32'd5, 32'd3, 32'd9, 32'hffff_ffff, 32'd1};
    logic [31:0] br_b [5] = '{32'd5, 32'd9, 32'd3, 32'd1, 32'hffff_ffff};

    ex_subsystem dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .stall        (stall),
        .fetch        (fetch),
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .result       (result),
        .result_valid (result_valid)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped on the first failure");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t ns: %s got 0x%08h expected 0x%08h",
                               $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] muldiv_ref(input logic [2:0] f3, input logic [31:0] a,
                                               input logic [31:0] b);
        longint      sa;
        longint      sb;
        longint      ua;
        longint      ub;
        logic [63:0] p;
        int          qa;
        int          qb;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ua = longint'({32'd0, a});
        ub = longint'({32'd0, b});
        qa = a;
        qb = b;
        case (f3)
            3'd0: begin
                p = sa * sb;
                return p[31:0];
            end
            3'd1: begin
                p = sa * sb;
                return p[63:32];
            end
            3'd2: begin
                p = sa * ub;
                return p[63:32];
            end
            3'd3: begin
                p = ua * ub;
                return p[63:32];
            end
            3'd4: begin
                if (b == 32'd0) return 32'hffff_ffff;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'h8000_0000;
                return qa / qb;
            end
            3'd5: return (b == 32'd0) ? 32'hffff_ffff : a / b;
            3'd6: begin
                if (b == 32'd0) return a;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'd0;
                return qa % qb;
            end
            default: return (b == 32'd0) ? a : a % b;
        endcase
    endfunction

    function automatic ex_pipe_pkg::ex_result_t ref_model(input ex_pipe_pkg::fetch_pkt_t pkt);
        ex_pipe_pkg::ex_result_t res;
        logic [31:0]             w;
        logic [31:0]             a;
        logic [31:0]             b;
        logic [4:0]              sh;
        logic [6:0]              opc;
        logic [2:0]              f3;
        logic [6:0]              f7;
        w   = pkt.word;
        a   = pkt.rs1_val;
        b   = pkt.rs2_val;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        res = '0;
        res.pc        = pkt.pc;
        res.br_target = pkt.pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        if (opc == rv_isa_pkg::OPC_OP_IMM) begin
            b = {{20{w[31]}}, w[31:20]};
        end
        sh = b[4:0];
        if (opc == rv_isa_pkg::OPC_OP || opc == rv_isa_pkg::OPC_OP_IMM) begin
            res.rf_wen = 1'b1;
            res.rd     = w[11:7];
            if (opc == rv_isa_pkg::OPC_OP && f7 == rv_isa_pkg::F7_MULDIV) begin
                res.alu_out = muldiv_ref(f3, a, b);
            end else begin
                case (f3)
                    3'd0: res.alu_out = (opc == rv_isa_pkg::OPC_OP &&
                                         f7 == rv_isa_pkg::F7_ALT) ? a - b : a + b;
                    3'd1: res.alu_out = a << sh;
                    3'd2: res.alu_out = {31'd0, $signed(a) < $signed(b)};
                    3'd3: res.alu_out = {31'd0, a < b};
                    3'd4: res.alu_out = a ^ b;
                    3'd5: res.alu_out = (f7 == rv_isa_pkg::F7_ALT) ?
                                        $unsigned($signed(a) >>> sh) : a >> sh;
                    3'd6: res.alu_out = a | b;
                    default: res.alu_out = a & b;
                endcase
            end
        end else if (opc == rv_isa_pkg::OPC_BRANCH) begin
            case (f3)
                3'd0: res.br_flg = (a == b);
                3'd1: res.br_flg = (a != b);
                3'd4: res.br_flg = $signed(a) < $signed(b);
                3'd5: res.br_flg = $signed(a) >= $signed(b);
                3'd6: res.br_flg = a < b;
                3'd7: res.br_flg = a >= b;
                default: res.br_flg = 1'b0;
            endcase
        end
        return res;
    endfunction

    task automatic next_rand(output logic [31:0] v);
        drv_seed = lcg_next(drv_seed);
        v = drv_seed;
    endtask

    task automatic rand_operand(output logic [31:0] v);
        logic [31:0] r;
        next_rand(r);
        v = r[29] ? r : {{24{r[31]}}, r[27:20]}; // Small values now and then
    endtask

    task automatic gen_base(output logic [31:0] word);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        next_rand(r);
        f3 = r[22:20];
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE;
        if (!r[31]) begin
            word = {f7, r[9:5], r[14:10], f3, r[19:15], rv_isa_pkg::OPC_OP};
        end else if (f3 == 3'd1 || f3 == 3'd5) begin
            word = {f7, r[9:5], r[14:10], f3, r[19:15], rv_isa_pkg::OPC_OP_IMM};
        end else begin
            word = {r[30:19], r[14:10], f3, r[19:15], rv_isa_pkg::OPC_OP_IMM};
        end
    endtask

    task automatic gen_muldiv(output logic [31:0] word);
        logic [31:0] r;
        next_rand(r);
        word = {rv_isa_pkg::F7_MULDIV, r[9:5], r[14:10], r[22:20], r[19:15], rv_isa_pkg::OPC_OP};
    endtask

    task automatic gen_branch(input logic [2:0] f3, output logic [31:0] word);
        logic [31:0] r;
        next_rand(r);
        word = {r[31:25], r[24:20], r[19:15], f3, r[11:7], rv_isa_pkg::OPC_BRANCH};
    endtask

    task automatic gen_any(output logic [31:0] word);
        logic [31:0] r;
        next_rand(r);
        case (r[31:30])
            2'd1: gen_muldiv(word);
            2'd2: gen_branch((r[27:26] == 2'd0) ? 3'd0 : {r[27:26], r[25]}, word);
            default: gen_base(word);
        endcase
    endtask

    task automatic drive_pkt(input logic [31:0] word, input logic [31:0] a, input logic [31:0] b);
        ex_pipe_pkg::fetch_pkt_t pkt;
        logic [31:0]             r;
        next_rand(r);
        pkt.pc      = {r[31:2], 2'b00};
        pkt.word    = rv_isa_pkg::rv_instr_u'(word);
        pkt.rs1_val = a;
        pkt.rs2_val = b;
        fetch <= pkt;
    endtask

    task automatic send_pkt(input logic [31:0] word, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        drive_pkt(word, a, b);
        fetch_valid <= 1'b1;
        @(posedge clk);
        while (!fetch_ready) @(posedge clk);
        fetch_valid <= 1'b0;
        if (use_gaps) begin
            next_rand(r);
            repeat (r[26:25]) @(posedge clk);
        end
    endtask

    task automatic send_random(input int n);
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        repeat (n) begin
            gen_any(word);
            rand_operand(a);
            rand_operand(b);
            send_pkt(word, a, b);
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    // The stall pattern changes only on the rising edge
    initial begin
        stall = 1'b0;
        forever begin
            @(posedge clk);
            stall_seed = lcg_next(stall_seed);
            if (stall_hold) stall <= 1'b1;
            else if (stall_rand) stall <= (stall_seed[30:29] == 2'b00);
            else stall <= 1'b0;
        end
    end

    // Values seen at the falling edge are the ones the next rising edge acts on
    always @(negedge clk) begin
        ex_pipe_pkg::ex_result_t exp;
        if (rst_n) begin
            if (result_valid && !stall) begin
                if (exp_q.size() == 0) begin
                    fail_run("A result came out with no instruction outstanding");
                end else begin
                    exp = exp_q.pop_front();
                    check_val("result.pc", result.pc, exp.pc);
                    check_val("result.rd", result.rd, exp.rd);
                    check_val("result.rf_wen", result.rf_wen, exp.rf_wen);
                    check_val("result.alu_out", result.alu_out, exp.alu_out);
                    check_val("result.br_flg", result.br_flg, exp.br_flg);
                    check_val("result.br_target", result.br_target, exp.br_target);
                end
            end
            if (flush) begin
                check_val("fetch_ready", fetch_ready, 1'b0);
                exp_q.delete();
            end
            if (fetch_valid && fetch_ready) begin
                exp_q.push_back(ref_model(fetch));
                accepted++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            fail_run($sformatf("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        int          base;
        rst_n       = 1'b0;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch       = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val("fetch_ready", fetch_ready, 1'b1);
        check_val("result_valid", result_valid, 1'b0);
        check_val("head_valid", dut_i.head_valid, 1'b0);
        check_val("credit_return", dut_i.credit_return, 1'b0);
        @(posedge clk);

        repeat (N_BASE) begin
            gen_base(word);
            rand_operand(a);
            rand_operand(b);
            send_pkt(word, a, b);
        end
        repeat (N_MULDIV) begin
            gen_muldiv(word);
            rand_operand(a);
            rand_operand(b);
            send_pkt(word, a, b);
        end
        for (int f = 4; f < 8; f++) begin
            gen_muldiv(word);
            word[14:12] = f[2:0];
            rand_operand(a);
            send_pkt(word, a, 32'd0); // Division by zero
        end
        gen_muldiv(word);
        word[14:12] = rv_isa_pkg::F3_DIV;
        send_pkt(word, 32'h8000_0000, 32'hffff_ffff);
        word[14:12] = rv_isa_pkg::F3_REM;
        send_pkt(word, 32'h8000_0000, 32'hffff_ffff);

        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                for (int k = 0; k < 5; k++) begin
                    gen_branch(f[2:0], word);
                    send_pkt(word, br_a[k], br_b[k]);
                end
            end
        end

        stall_rand = 1'b1;
        use_gaps   = 1'b1;
        send_random(N_STREAM);
        wait_drained();

        // Hold stall and count how many packets the credits let in
        stall_rand = 1'b0;
        stall_hold = 1'b1;
        repeat (2) @(posedge clk);
        base = accepted;
        gen_any(word);
        drive_pkt(word, 32'd7, 32'd3);
        fetch_valid <= 1'b1;
        repeat (12) begin
            @(posedge clk);
            if (fetch_ready) begin
                gen_any(word);
                rand_operand(a);
                drive_pkt(word, a, 32'd3);
            end
        end
        fetch_valid <= 1'b0;
        check_val("accepted_under_stall", accepted - base, ex_pipe_pkg::UOP_QUEUE_DEPTH + 1);
        stall_hold = 1'b0;
        wait_drained();

        stall_rand = 1'b1;
        send_random(N_FLUSH / 2);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        send_random(N_FLUSH / 2);
        wait_drained();

        stall_rand = 1'b0;
        use_gaps   = 1'b0;
        foreach (br_a[k]) begin
            next_rand(word);
            word[6:0] = (k == 0) ? 7'b0000011 : (k == 1) ? 7'b0100011 :
                        (k == 2) ? 7'b1101111 : (k == 3) ? 7'b0110111 : 7'b0010111;
            rand_operand(a);
            send_pkt(word, a, br_b[k]);
        end
        next_rand(word);
        word[6:0] = 7'b1100111;
        send_pkt(word, 32'd1, 32'd2);
        wait_drained();

        if (exp_q.size() != 0 || accepted == 0) begin
            fail_run("Some accepted instructions never produced a result");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule
